// ==== list.f ====
+incdir+logic
logic/ilkn_pkg.sv
logic/lane_word_if.sv
logic/lane_fanout.sv
logic/lane_framer.sv
logic/lane_deskew.sv
logic/ilkn_rx_top.sv
sim/tb_ilkn_rx.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module tb_ilkn_rx -f list.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_ilkn_rx)"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir

// ==== sim/tb_ilkn_rx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ilkn_settings.svh"

module tb_ilkn_rx;

	localparam int LANES = `ILKN_LANES;
	localparam int LEN = `ILKN_META_FRAME_LEN;
	localparam int N_ROWS = 5;
	localparam int MAX_FRAMES = 16;
	// frame that carries the injected fault
	localparam int INJ_FRAME = 5;
	// reset, idle check, skew tail and drain time per row
	localparam int ROW_SLACK = 48;
	localparam logic [1:0] INJ_NONE = 2'd0;
	localparam logic [1:0] INJ_HDR = 2'd1;
	localparam logic [1:0] INJ_SYNC = 2'd2;

	// one scenario, skew is counted in clock cycles
	typedef struct packed {
		logic [LANES-1:0][2:0] skew;
		logic [LANES-1:0] invert;
		logic [1:0] inj;
		logic [1:0] inj_lane;
		logic [LANES-1:0] exp_ferr;
		logic [LANES-1:0] exp_msync;
		logic [7:0] frames;
	} scen_t;

	logic clk;
	logic arst_n;
	logic [LANES*66-1:0] rx_words;
	logic [LANES-1:0] rx_valid;
	logic [LANES-1:0] lane_invert;
	logic locked;
	logic [LANES*65-1:0] out_words;
	logic out_valid;
	logic overflow;
	logic [LANES-1:0] word_locked;
	logic [LANES-1:0] sync_locked;
	logic [LANES-1:0] framing_error;
	logic [LANES-1:0] missing_sync;

	scen_t rows [N_ROWS];
	logic [31:0] lo_bits [LANES][MAX_FRAMES*LEN];
	logic [31:0] lcg_state;
	int cur_row;
	int cur_frames;
	int value_errs;
	int other_errs;
	int timeout_limit = 0;
	int cycle_cnt = 0;

	// sticky observations, cleared while reset is low
	logic [LANES-1:0] ferr_seen;
	logic [LANES-1:0] msync_seen;
	logic [LANES-1:0] wl_fell;
	logic [LANES-1:0] sl_fell;
	logic [LANES-1:0] prev_wl;
	logic [LANES-1:0] prev_sl;
	logic ovf_seen;
	logic lock_fell;
	logic prev_locked;
	// have_prev marks a group already seen in the current lock interval
	// prev_f and prev_w hold the position of the last group delivered
	logic have_prev;
	int prev_f;
	int prev_w;
	int groups_in_lock;

	ilkn_rx_top UUT (
		.clk(clk),
		.arst_n(arst_n),
		.rx_words(rx_words),
		.rx_valid(rx_valid),
		.lane_invert(lane_invert),
		.locked(locked),
		.out_words(out_words),
		.out_valid(out_valid),
		.overflow(overflow),
		.word_locked(word_locked),
		.sync_locked(sync_locked),
		.framing_error(framing_error),
		.missing_sync(missing_sync)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// the run is bounded by the total stream length of all rows
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_limit) begin
			$display("timeout, the run is still going after %0d cycles", cycle_cnt);
			$display("%0d value mismatches, %0d other failures", value_errs, other_errs + 1);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// stream generator

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// word 0 is the sync word, word 1 the scrambler state word with bit 63
	// clear, word 2 a burst control word with bit 63 set, the rest is data
	function automatic logic [65:0] build_raw(input int lane, input int frame, input int word);
		logic [1:0] hdr;
		logic [63:0] payload;
		hdr = (word <= 2) ? 2'b10 : 2'b01;
		if (word == 0) begin
			payload = ilkn_pkg::SYNC_PATTERN;
		end else begin
			payload = {word == 2, 7'(lane), 8'(frame), 8'(word), 8'(cur_row),
				lo_bits[lane][frame*LEN + word]};
		end
		return {hdr, payload};
	endfunction

	task automatic fill_lcg();
		for (int l = 0; l < LANES; l++) begin
			for (int n = 0; n < cur_frames*LEN; n++) begin
				lcg_state = lcg_next(lcg_state);
				lo_bits[l][n] = lcg_state;
			end
		end
	endtask

	// the source sends a word every other cycle, and each lane starts its
	// skew cycles late, so the deskew FIFOs can drain to a common sync word
	task automatic drive_lanes(input int c);
		logic [65:0] w;
		int t;
		int n;
		for (int l = 0; l < LANES; l++) begin
			t = c - int'(rows[cur_row].skew[l]);
			if (t >= 0 && t % 2 == 0 && t / 2 < cur_frames*LEN) begin
				n = t / 2;
				w = build_raw(l, n / LEN, n % LEN);
				if (l == int'(rows[cur_row].inj_lane)) begin
					if (rows[cur_row].inj == INJ_HDR && n == INJ_FRAME*LEN + 3) begin
						w[65:64] = 2'b00;
					end
					if (rows[cur_row].inj == INJ_SYNC && n == INJ_FRAME*LEN) begin
						w[63:0] = w[63:0] ^ 64'h1;
					end
				end
				// a backwards lane is sent with every bit flipped
				if (rows[cur_row].invert[l]) begin
					w = ~w;
				end
				rx_words[66*l +: 66] = w;
				rx_valid[l] = 1'b1;
			end else begin
				rx_words[66*l +: 66] = '0;
				rx_valid[l] = 1'b0;
			end
		end
	endtask

	////////////////////////////////////////
	// checker

	task automatic check_value(input string name, input logic [64:0] got, input logic [64:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	// every group must hold the next non-framing word of the stream on all lanes
	task automatic check_group();
		logic [65:0] raw;
		int exp_f;
		int exp_w;
		if (!have_prev) begin
			// alignment happens on a sync word, so the first output is word 2
			// and its frame lies beyond every frame delivered before
			exp_f = int'(out_words[55:48]);
			exp_w = 2;
			if (exp_f <= prev_f) begin
				other_errs++;
				$display("output restarts at frame %0d after frame %0d was delivered",
					exp_f, prev_f);
			end
		end else if (prev_w == LEN - 1) begin
			exp_f = prev_f + 1;
			exp_w = 2;
		end else begin
			exp_f = prev_f;
			exp_w = prev_w + 1;
		end
		if (exp_f >= cur_frames) begin
			other_errs++;
			$display("output group carries frame %0d, only %0d frames were sent", exp_f,
				cur_frames);
		end else begin
			for (int l = 0; l < LANES; l++) begin
				raw = build_raw(l, exp_f, exp_w);
				check_value($sformatf("out_words lane %0d", l), out_words[65*l +: 65],
					{raw[65:64] == 2'b10, raw[63:0]});
			end
		end
		prev_f = exp_f;
		prev_w = exp_w;
		have_prev = 1'b1;
		groups_in_lock++;
	endtask

	task automatic observe();
		if (!arst_n) begin
			ferr_seen = '0;
			msync_seen = '0;
			wl_fell = '0;
			sl_fell = '0;
			prev_wl = '0;
			prev_sl = '0;
			ovf_seen = 1'b0;
			lock_fell = 1'b0;
			prev_locked = 1'b0;
			have_prev = 1'b0;
			prev_f = -1;
			groups_in_lock = 0;
		end else begin
			ferr_seen = ferr_seen | framing_error;
			msync_seen = msync_seen | missing_sync;
			ovf_seen = ovf_seen | overflow;
			wl_fell = wl_fell | (prev_wl & ~word_locked);
			sl_fell = sl_fell | (prev_sl & ~sync_locked);
			if (prev_locked && !locked) begin
				lock_fell = 1'b1;
			end
			// a new lock interval restarts the sequence tracking
			if (!prev_locked && locked) begin
				have_prev = 1'b0;
				groups_in_lock = 0;
			end
			if (out_valid) begin
				check_group();
			end
			prev_wl = word_locked;
			prev_sl = sync_locked;
			prev_locked = locked;
		end
	endtask

	// outputs are sampled and inputs driven 5 ns after the rising edge
	task automatic step_cycle();
		@(posedge clk);
		#5;
		observe();
	endtask

	task automatic check_idle();
		check_value("locked", 65'(locked), 65'(0));
		check_value("out_valid", 65'(out_valid), 65'(0));
		check_value("overflow", 65'(overflow), 65'(0));
		check_value("word_locked", 65'(word_locked), 65'(0));
		check_value("sync_locked", 65'(sync_locked), 65'(0));
		check_value("framing_error", 65'(framing_error), 65'(0));
		check_value("missing_sync", 65'(missing_sync), 65'(0));
	endtask

	////////////////////////////////////////
	// scenario loop

	initial begin
		int total;
		int quiet;
		arst_n = 1'b0;
		rx_words = '0;
		rx_valid = '0;
		lane_invert = '0;
		lcg_state = 32'hcdba;
		value_errs = 0;
		other_errs = 0;

		// skews are listed lane 3 first, lane 0 last
		rows[0] = '{{3'd0, 3'd0, 3'd0, 3'd0}, 4'b0000, INJ_NONE, 2'd0, 4'b0000, 4'b0000, 8'd8};
		rows[1] = '{{3'd5, 3'd3, 3'd2, 3'd0}, 4'b0000, INJ_NONE, 2'd0, 4'b0000, 4'b0000, 8'd10};
		rows[2] = '{{3'd0, 3'd4, 3'd1, 3'd5}, 4'b1010, INJ_NONE, 2'd0, 4'b0000, 4'b0000, 8'd10};
		rows[3] = '{{3'd3, 3'd0, 3'd4, 3'd1}, 4'b0101, INJ_HDR, 2'd2, 4'b0100, 4'b0000, 8'd14};
		rows[4] = '{{3'd2, 3'd5, 3'd0, 3'd3}, 4'b0011, INJ_SYNC, 2'd1, 4'b0000, 4'b0010, 8'd13};

		total = 0;
		for (int r = 0; r < N_ROWS; r++) begin
			total += 2 * int'(rows[r].frames) * LEN + ROW_SLACK;
		end
		timeout_limit = total + 200;

		for (int r = 0; r < N_ROWS; r++) begin
			cur_row = r;
			cur_frames = int'(rows[r].frames);
			fill_lcg();
			step_cycle();
			arst_n = 1'b0;
			rx_valid = '0;
			lane_invert = rows[r].invert;
			repeat (8) step_cycle();
			arst_n = 1'b1;
			step_cycle();
			check_idle();

			for (int c = 0; c < 2*cur_frames*LEN + 8; c++) begin
				drive_lanes(c);
				step_cycle();
			end
			rx_valid = '0;
			rx_words = '0;

			// the row is over once the output has gone quiet
			quiet = 0;
			while (quiet < 8) begin
				step_cycle();
				quiet = out_valid ? 0 : quiet + 1;
			end

			check_value("framing_error seen", 65'(ferr_seen), 65'(rows[r].exp_ferr));
			check_value("missing_sync seen", 65'(msync_seen), 65'(rows[r].exp_msync));
			check_value("word_locked fell", 65'(wl_fell), 65'(rows[r].exp_ferr));
			check_value("sync_locked fell", 65'(sl_fell),
				65'(rows[r].exp_ferr | rows[r].exp_msync));
			check_value("overflow seen", 65'(ovf_seen), 65'(0));
			check_value("locked fell", 65'(lock_fell), 65'(rows[r].inj != INJ_NONE));
			check_value("locked at row end", 65'(locked), 65'(1));
			if (groups_in_lock == 0) begin
				other_errs++;
				$display("row %0d gave no word group after its last lock", r);
			end
		end

		$display("%0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/ilkn_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ilkn_settings.svh"

module ilkn_rx_top (
	input wire clk,
	input wire arst_n,
	input wire [`ILKN_LANES*66-1:0] rx_words,
	input wire [`ILKN_LANES-1:0] rx_valid,
	input wire [`ILKN_LANES-1:0] lane_invert,
	output wire locked,
	output wire [`ILKN_LANES*65-1:0] out_words,
	output wire out_valid,
	output wire overflow,
	output wire [`ILKN_LANES-1:0] word_locked,
	output wire [`ILKN_LANES-1:0] sync_locked,
	output wire [`ILKN_LANES-1:0] framing_error,
	output wire [`ILKN_LANES-1:0] missing_sync
);

	ilkn_pkg::lane_raw_t lane_raw [`ILKN_LANES];
	wire [`ILKN_LANES-1:0] lane_raw_valid;

	// one framed word channel per lane
	lane_word_if lw [`ILKN_LANES] ();

	////////////////////////////////////////
	// input registers and polarity

	lane_fanout u_fanout (
		.clk(clk),
		.arst_n(arst_n),
		.rx_words(rx_words),
		.rx_valid(rx_valid),
		.lane_invert(lane_invert),
		.lane_raw(lane_raw),
		.lane_raw_valid(lane_raw_valid)
	);

	////////////////////////////////////////
	// per lane framing

	for (genvar i = 0; i < `ILKN_LANES; i++) begin : g_lane
		lane_framer u_framer (
			.clk(clk),
			.arst_n(arst_n),
			.raw(lane_raw[i]),
			.raw_valid(lane_raw_valid[i]),
			.lw(lw[i]),
			.word_locked(word_locked[i]),
			.framing_error(framing_error[i]),
			.missing_sync(missing_sync[i])
		);

		// the lane sync status is also a status output
		assign sync_locked[i] = lw[i].sync_locked;
	end

	////////////////////////////////////////
	// lane alignment and striping

	lane_deskew u_deskew (
		.clk(clk),
		.arst_n(arst_n),
		.lanes(lw),
		.locked(locked),
		.out_words(out_words),
		.out_valid(out_valid),
		.overflow(overflow)
	);

endmodule

`default_nettype wire

// ==== logic/lane_deskew.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ilkn_settings.svh"

module lane_deskew (
	input wire clk,
	input wire arst_n,
	lane_word_if.deskew lanes [`ILKN_LANES],
	output logic locked,
	output logic [`ILKN_LANES*65-1:0] out_words,
	output logic out_valid,
	output logic overflow
);

	localparam int N = `ILKN_LANES;
	localparam int AW = $clog2(`ILKN_SKEW_DEPTH);
	localparam int PW = AW + 1;

	ilkn_pkg::lane_word_t in_word [N];
	logic [N-1:0] in_valid;
	logic [N-1:0] in_sync;
	logic [N-1:0] in_slock;
	ilkn_pkg::lane_word_t mem_word [N][`ILKN_SKEW_DEPTH];
	logic [`ILKN_SKEW_DEPTH-1:0] mem_sync [N];
	// pointers carry one extra bit to tell full from empty
	logic [PW-1:0] wr_ptr [N];
	logic [PW-1:0] rd_ptr [N];
	ilkn_pkg::lane_word_t head_word [N];
	logic [N-1:0] head_sync;
	logic [N-1:0] empty;
	logic [N-1:0] full;
	logic [N-1:0] pop;
	logic all_slock;
	logic align;
	logic overflow_hit;
	logic sync_agree;
	logic framing_grp;

	////////////////////////////////////////
	// per lane skew FIFOs

	for (genvar i = 0; i < N; i++) begin : g_lane
		logic [PW-1:0] fill;

		assign in_word[i] = lanes[i].word;
		assign in_valid[i] = lanes[i].valid;
		assign in_sync[i] = lanes[i].sync;
		assign in_slock[i] = lanes[i].sync_locked;

		assign fill = wr_ptr[i] - rd_ptr[i];
		assign empty[i] = fill == '0;
		assign full[i] = fill == PW'(`ILKN_SKEW_DEPTH);
		assign head_word[i] = mem_word[i][rd_ptr[i][AW-1:0]];
		assign head_sync[i] = mem_sync[i][rd_ptr[i][AW-1:0]];

		always_ff @(posedge clk) begin
			if (in_valid[i]) begin
				mem_word[i][wr_ptr[i][AW-1:0]] <= in_word[i];
				mem_sync[i][wr_ptr[i][AW-1:0]] <= in_sync[i];
			end
		end

		// an overflow anywhere empties every lane so they restart together
		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
			end else if (overflow_hit) begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
			end else begin
				if (in_valid[i]) begin
					wr_ptr[i] <= wr_ptr[i] + 1'b1;
				end
				if (pop[i]) begin
					rd_ptr[i] <= rd_ptr[i] + 1'b1;
				end
			end
		end

		// lane 0 lands in the low bits of the striped output
		always_ff @(posedge clk) begin
			if (&pop) begin
				out_words[65*i +: 65] <= head_word[i];
			end
		end

		a_no_empty_pop: assert property (@(posedge clk) disable iff (!arst_n)
			!(pop[i] && empty[i]))
			else $error("deskew FIFO popped while empty");
	end

	////////////////////////////////////////
	// alignment

	assign all_slock = &in_slock;
	// a push into a full FIFO is only safe when the head leaves in the same cycle
	assign overflow_hit = |(in_valid & full & ~pop);
	// aligned lanes pop sync words on the same cycle or not at all
	assign sync_agree = (&head_sync) || !(|head_sync);
	// aligned lanes share the word class, so lane 0 speaks for the group
	assign framing_grp = head_word[0].ctrl && !head_word[0].data[63];

	always_comb begin
		pop = '0;
		align = 1'b0;
		if (locked) begin
			// lockstep drain whenever every lane has a word waiting
			if (all_slock && !(|empty)) begin
				pop = '1;
			end
		end else if (all_slock && !(|empty) && (&head_sync)) begin
			// every head is a sync word, this group defines the alignment
			pop = '1;
			align = 1'b1;
		end else begin
			// discard up to a sync word and park there
			// a parked sync is given up once its FIFO fills, since the
			// matching sync on the other lanes would have come by then
			for (int i = 0; i < N; i++) begin
				pop[i] = !empty[i] && (!head_sync[i] || full[i]);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			locked <= 1'b0;
			out_valid <= 1'b0;
			overflow <= 1'b0;
		end else begin
			overflow <= overflow_hit;
			out_valid <= 1'b0;
			if (overflow_hit) begin
				locked <= 1'b0;
			end else if (align) begin
				locked <= 1'b1;
			end else if (locked) begin
				if (!all_slock) begin
					locked <= 1'b0;
				end else if (&pop) begin
					if (!sync_agree) begin
						locked <= 1'b0;
					end else begin
						// framing-layer words end here
						out_valid <= !framing_grp;
					end
				end
			end
		end
	end

	// every output group was popped under lock and did not break it
	a_out_needs_lock: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> (locked && $past(locked)))
		else $error("out_valid outside of a locked interval");

endmodule

`default_nettype wire

// ==== logic/lane_framer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ilkn_settings.svh"

module lane_framer (
	input wire clk,
	input wire arst_n,
	input wire ilkn_pkg::lane_raw_t raw,
	input wire raw_valid,
	lane_word_if.framer lw,
	output logic word_locked,
	output logic framing_error,
	output logic missing_sync
);

	localparam int LOCK_W = $clog2(`ILKN_WORD_LOCK);
	localparam int POS_W = $clog2(`ILKN_META_FRAME_LEN + 1);

	// legal headers seen in a row while hunting for word lock
	logic [LOCK_W-1:0] hdr_cnt;
	// position of the next word relative to the last sync word
	logic [POS_W-1:0] frame_pos;
	// one sync word has been seen, frame_pos is meaningful
	logic sync_armed;
	logic hdr_legal;
	logic is_ctrl;
	logic is_sync;
	logic sync_slot;

	////////////////////////////////////////
	// header decode

	// 01 is data and 10 is control, the other two codes are line errors
	assign hdr_legal = (raw.hdr == 2'b01) || (raw.hdr == 2'b10);
	assign is_ctrl = raw.hdr == 2'b10;
	assign is_sync = is_ctrl && (raw.payload == ilkn_pkg::SYNC_PATTERN);

	// the word that should carry the next sync
	assign sync_slot = frame_pos == POS_W'(`ILKN_META_FRAME_LEN);

	// framed word, one cycle behind the raw word
	always_ff @(posedge clk) begin
		lw.word.ctrl <= is_ctrl;
		lw.word.data <= raw.payload;
	end

	////////////////////////////////////////
	// word lock and meta-frame tracking

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hdr_cnt <= '0;
			word_locked <= 1'b0;
			frame_pos <= '0;
			sync_armed <= 1'b0;
			lw.valid <= 1'b0;
			lw.sync <= 1'b0;
			lw.sync_locked <= 1'b0;
			framing_error <= 1'b0;
			missing_sync <= 1'b0;
		end else begin
			// words only go downstream once the lane is word locked
			lw.valid <= raw_valid && hdr_legal && word_locked;
			lw.sync <= is_sync;
			framing_error <= raw_valid && !hdr_legal;
			missing_sync <= 1'b0;
			if (raw_valid) begin
				if (!hdr_legal) begin
					// bad header, start over from scratch
					hdr_cnt <= '0;
					word_locked <= 1'b0;
					sync_armed <= 1'b0;
					lw.sync_locked <= 1'b0;
				end else if (!word_locked) begin
					hdr_cnt <= hdr_cnt + 1'b1;
					if (hdr_cnt == LOCK_W'(`ILKN_WORD_LOCK - 1)) begin
						word_locked <= 1'b1;
					end
				end else if (!sync_armed) begin
					// hunting for the first sync word
					if (is_sync) begin
						sync_armed <= 1'b1;
						frame_pos <= POS_W'(1);
					end
				end else if (sync_slot) begin
					if (is_sync) begin
						// second sync at the right spacing locks the lane
						lw.sync_locked <= 1'b1;
						frame_pos <= POS_W'(1);
					end else begin
						missing_sync <= 1'b1;
						sync_armed <= 1'b0;
						lw.sync_locked <= 1'b0;
					end
				end else if (is_sync) begin
					// sync arrived early, take it as the new frame start
					frame_pos <= POS_W'(1);
					lw.sync_locked <= 1'b0;
				end else begin
					frame_pos <= frame_pos + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// checks

	// the error pulse belongs to a real word of the previous cycle and
	// arrives together with the loss of word lock and sync lock
	a_err_needs_word: assert property (@(posedge clk) disable iff (!arst_n)
		framing_error |-> ($past(raw_valid) && !word_locked && !lw.sync_locked))
		else $error("framing_error without a valid word or with lock still held");

	// nothing reaches the deskew stage from an unlocked lane
	a_valid_needs_lock: assert property (@(posedge clk) disable iff (!arst_n)
		lw.valid |-> word_locked)
		else $error("lane word pushed while word_locked is low");

endmodule

`default_nettype wire

// ==== logic/lane_fanout.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ilkn_settings.svh"

module lane_fanout (
	input wire clk,
	input wire arst_n,
	// lane 0 sits in the low 66 bits of the flat bus
	input wire [`ILKN_LANES*66-1:0] rx_words,
	input wire [`ILKN_LANES-1:0] rx_valid,
	// a set bit means that lane is wired with swapped polarity
	input wire [`ILKN_LANES-1:0] lane_invert,
	output ilkn_pkg::lane_raw_t lane_raw [`ILKN_LANES],
	output logic [`ILKN_LANES-1:0] lane_raw_valid
);

	////////////////////////////////////////
	// strobes

	// per lane valid strobes, one cycle behind the input bus
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lane_raw_valid <= '0;
		end else begin
			lane_raw_valid <= rx_valid;
		end
	end

	////////////////////////////////////////
	// per lane slicing and polarity fix

	for (genvar i = 0; i < `ILKN_LANES; i++) begin : g_lane
		// a backwards lane has every bit flipped, header included, so the
		// whole 66 bit word is xored with the lane's invert flag
		// after this the framer sees a correctly wired lane
		always_ff @(posedge clk) begin
			lane_raw[i] <= ilkn_pkg::lane_raw_t'(rx_words[66*i +: 66] ^ {66{lane_invert[i]}});
		end
	end

endmodule

`default_nettype wire

// ==== logic/lane_word_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one framed lane word on its way from a framer to the deskew stage
// there is no ready signal, every cycle with valid high is a push
interface lane_word_if;

	// control bit plus 64 data bits
	ilkn_pkg::lane_word_t word;

	// qualifies word for this cycle
	logic valid;

	// high when word is the meta-frame sync word, saves a comparator per lane
	// in the deskew stage
	logic sync;

	// level flag, the lane has seen sync words at the expected spacing
	logic sync_locked;

	// the framer owns every signal
	modport framer (output word, output valid, output sync, output sync_locked);

	// the deskew stage only listens
	modport deskew (input word, input valid, input sync, input sync_locked);

endinterface

`default_nettype wire

// ==== logic/ilkn_pkg.sv ====
`default_nettype none

package ilkn_pkg;

	////////////////////////////////////////
	// lane word formats

	// raw word as it leaves the SERDES side, already aligned and descrambled
	// hdr 01 is data, 10 is control, anything else is a framing error
	typedef struct packed {
		logic [1:0] hdr;
		logic [63:0] payload;
	} lane_raw_t;

	// framed word after the header has been reduced to one control bit
	typedef struct packed {
		logic ctrl;
		logic [63:0] data;
	} lane_word_t;

	////////////////////////////////////////
	// control word payloads

	// meta-frame sync word, bit 63 clear so it counts as a framing-layer word
	localparam logic [63:0] SYNC_PATTERN = 64'h78f6_78f6_78f6_78f6;

endpackage

`default_nettype wire

// ==== logic/ilkn_settings.svh ====
`ifndef ILKN_SETTINGS_SVH
`define ILKN_SETTINGS_SVH

// number of serial lanes striped together
`define ILKN_LANES 4

// words per meta-frame, counted from one sync word to the next
// and including the sync word itself; any value of 4 or more works
`define ILKN_META_FRAME_LEN 8

// consecutive legal sync headers needed before a lane is word locked
`define ILKN_WORD_LOCK 8

// depth of each deskew FIFO, a power of two
// the tolerated lane skew is strictly below this many words
`define ILKN_SKEW_DEPTH 8

`endif
